/* logic/cdc_fifo_defines.svh */
`ifndef CDC_FIFO_DEFINES_SVH
`define CDC_FIFO_DEFINES_SVH

// Number of entries, must be a power of two and at least 2
`define CDC_FIFO_DEPTH 8

// Count must be able to hold the value DEPTH itself
`define CDC_FIFO_COUNT_WIDTH ($clog2(`CDC_FIFO_DEPTH + 1))

// Address is the low bits of a count
`define CDC_FIFO_ADDR_WIDTH ($clog2(`CDC_FIFO_DEPTH))

// Flops per clock domain crossing
`define CDC_FIFO_SYNC_STAGES 2

// Registers on the exported reset-active signal
// The exported count gets one stage more than this
`define CDC_FIFO_REG_RESET_ACTIVE 1

`endif

/* logic/cdc_fifo_pkg.sv */
`include "cdc_fifo_defines.svh"

package cdc_fifo_pkg;

  typedef logic [`CDC_FIFO_COUNT_WIDTH-1:0] count_t;
  typedef logic [`CDC_FIFO_ADDR_WIDTH-1:0] addr_t;

  typedef struct packed {
    logic [3:0]  tag;
    logic        last;
    logic [15:0] data;
  } packet_t;

  function automatic count_t bin2gray(count_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic count_t gray2bin(count_t gray);
    count_t bin;
    bin[$bits(count_t)-1] = gray[$bits(count_t)-1];
    for (int i = $bits(count_t) - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

/* logic/cdc_fifo_sync.sv */
`timescale 1ns/1ps
`include "cdc_fifo_defines.svh"

module cdc_fifo_sync #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst,
  input  T     in,
  output T     out
);

  T stage_q [`CDC_FIFO_SYNC_STAGES];

  // Only Gray counts and single bits are sent through here
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `CDC_FIFO_SYNC_STAGES; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= in;
      for (int i = 1; i < `CDC_FIFO_SYNC_STAGES; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign out = stage_q[`CDC_FIFO_SYNC_STAGES-1];

  // Far side must have flushed its export chain once this side is out of reset
  in_known_a: assert property (@(posedge clk) disable iff (rst)
    !$isunknown(in))
    else $error("sync input is unknown after reset");

endmodule

/* logic/cdc_fifo_push_flag_mgr.sv */
`timescale 1ns/1ps
`include "cdc_fifo_defines.svh"

module cdc_fifo_push_flag_mgr (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  push_beat,
  input  cdc_fifo_pkg::count_t  pop_count_gray,
  input  logic                  reset_active_pop,
  output cdc_fifo_pkg::count_t  push_count_gray,
  output cdc_fifo_pkg::addr_t   wr_addr,
  output logic                  full,
  output logic                  reset_active_push
);

  // Count must not reach the far side before reset-active does
  localparam int export_stages = `CDC_FIFO_REG_RESET_ACTIVE + 1;

  cdc_fifo_pkg::count_t push_count;
  cdc_fifo_pkg::count_t push_count_next;
  cdc_fifo_pkg::count_t pop_count;
  cdc_fifo_pkg::count_t pop_count_saved;
  cdc_fifo_pkg::count_t pop_count_visible;
  cdc_fifo_pkg::count_t used;
  cdc_fifo_pkg::count_t free_slots;
  cdc_fifo_pkg::count_t export_q [export_stages];

  // Held at zero in reset so the export chain flushes to zero
  assign push_count_next = rst ? '0 : push_count + cdc_fifo_pkg::count_t'(push_beat);

  always_ff @(posedge clk) begin
    if (rst) begin
      push_count <= '0;
    end else begin
      push_count <= push_count_next;
    end
  end

  always_ff @(posedge clk) begin
    export_q[0] <= cdc_fifo_pkg::bin2gray(push_count_next);
    for (int i = 1; i < export_stages; i++) begin
      export_q[i] <= export_q[i-1];
    end
  end

  assign push_count_gray = export_q[export_stages-1];

  generate
    if (`CDC_FIFO_REG_RESET_ACTIVE == 0) begin : g_reset_active_comb
      assign reset_active_push = rst;
    end else begin : g_reset_active_reg
      logic reset_active_q [`CDC_FIFO_REG_RESET_ACTIVE];
      always_ff @(posedge clk) begin
        reset_active_q[0] <= rst;
        for (int i = 1; i < `CDC_FIFO_REG_RESET_ACTIVE; i++) begin
          reset_active_q[i] <= reset_active_q[i-1];
        end
      end
      assign reset_active_push = reset_active_q[`CDC_FIFO_REG_RESET_ACTIVE-1];
    end
  endgenerate

  assign pop_count = cdc_fifo_pkg::gray2bin(pop_count_gray);

  // Last pop count seen before the pop side went into reset
  always_ff @(posedge clk) begin
    if (rst) begin
      pop_count_saved <= '0;
    end else if (!reset_active_pop) begin
      pop_count_saved <= pop_count;
    end
  end

  assign pop_count_visible = reset_active_pop ? pop_count_saved : pop_count;

  // Wrapped difference, the count range is twice the depth
  assign used       = push_count - pop_count_visible;
  assign free_slots = cdc_fifo_pkg::count_t'(`CDC_FIFO_DEPTH) - used;
  assign full       = (free_slots == '0);
  assign wr_addr    = push_count[`CDC_FIFO_ADDR_WIDTH-1:0];

  no_push_when_full_a: assert property (@(posedge clk) disable iff (rst)
    !(push_beat && full))
    else $error("push accepted while FIFO is full");

endmodule

/* logic/cdc_fifo_pop_flag_mgr.sv */
`timescale 1ns/1ps
`include "cdc_fifo_defines.svh"

module cdc_fifo_pop_flag_mgr (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  pop_beat,
  input  cdc_fifo_pkg::count_t  push_count_gray,
  input  logic                  reset_active_push,
  output cdc_fifo_pkg::count_t  pop_count_gray,
  output cdc_fifo_pkg::addr_t   rd_addr,
  output cdc_fifo_pkg::count_t  items,
  output logic                  empty,
  output logic                  reset_active_pop
);

  // Same ordering rule as on the push side
  localparam int export_stages = `CDC_FIFO_REG_RESET_ACTIVE + 1;

  cdc_fifo_pkg::count_t pop_count;
  cdc_fifo_pkg::count_t pop_count_next;
  cdc_fifo_pkg::count_t push_count;
  cdc_fifo_pkg::count_t push_count_saved;
  cdc_fifo_pkg::count_t push_count_visible;
  cdc_fifo_pkg::count_t export_q [export_stages];

  assign pop_count_next = rst ? '0 : pop_count + cdc_fifo_pkg::count_t'(pop_beat);

  always_ff @(posedge clk) begin
    if (rst) begin
      pop_count <= '0;
    end else begin
      pop_count <= pop_count_next;
    end
  end

  // Gray export of the next pop count
  always_ff @(posedge clk) begin
    export_q[0] <= cdc_fifo_pkg::bin2gray(pop_count_next);
    for (int i = 1; i < export_stages; i++) begin
      export_q[i] <= export_q[i-1];
    end
  end

  assign pop_count_gray = export_q[export_stages-1];

  generate
    if (`CDC_FIFO_REG_RESET_ACTIVE == 0) begin : g_reset_active_comb
      assign reset_active_pop = rst;
    end else begin : g_reset_active_reg
      logic reset_active_q [`CDC_FIFO_REG_RESET_ACTIVE];
      always_ff @(posedge clk) begin
        reset_active_q[0] <= rst;
        for (int i = 1; i < `CDC_FIFO_REG_RESET_ACTIVE; i++) begin
          reset_active_q[i] <= reset_active_q[i-1];
        end
      end
      assign reset_active_pop = reset_active_q[`CDC_FIFO_REG_RESET_ACTIVE-1];
    end
  endgenerate

  assign push_count = cdc_fifo_pkg::gray2bin(push_count_gray);

  // Freeze the push count while the push side is in reset
  always_ff @(posedge clk) begin
    if (rst) begin
      push_count_saved <= '0;
    end else if (!reset_active_push) begin
      push_count_saved <= push_count;
    end
  end

  assign push_count_visible = reset_active_push ? push_count_saved : push_count;

  assign items   = push_count_visible - pop_count;
  assign empty   = (items == '0);
  assign rd_addr = pop_count[`CDC_FIFO_ADDR_WIDTH-1:0];

  // Push side full logic must keep this bounded
  no_items_overflow_a: assert property (@(posedge clk) disable iff (rst)
    items <= cdc_fifo_pkg::count_t'(`CDC_FIFO_DEPTH))
    else $error("item count 0x%0h exceeds depth", items);

  no_pop_when_empty_a: assert property (@(posedge clk) disable iff (rst)
    !(pop_beat && empty))
    else $error("pop accepted while FIFO is empty");

endmodule

/* logic/cdc_fifo_storage.sv */
`timescale 1ns/1ps
`include "cdc_fifo_defines.svh"

module cdc_fifo_storage #(
  parameter type T = cdc_fifo_pkg::packet_t
) (
  input  logic                 push_clk,
  input  logic                 wr_en,
  input  cdc_fifo_pkg::addr_t  wr_addr,
  input  T                     wr_data,
  input  cdc_fifo_pkg::addr_t  rd_addr,
  output T                     rd_data
);

  T mem [`CDC_FIFO_DEPTH];

  always_ff @(posedge push_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read side sees an entry only after its push count has crossed over
  assign rd_data = mem[rd_addr];

  // Addresses come straight from the low count bits, so the depth must
  // fill the address space and divide the count range
  depth_pow2_a: assert property (@(posedge push_clk)
    ((1 << `CDC_FIFO_ADDR_WIDTH) == `CDC_FIFO_DEPTH) &&
    ((1 << `CDC_FIFO_COUNT_WIDTH) == 2 * `CDC_FIFO_DEPTH) &&
    (`CDC_FIFO_DEPTH >= 2))
    else $error("FIFO depth must be a power of two of at least 2");

endmodule

/* logic/cdc_fifo.sv */
`timescale 1ns/1ps

module cdc_fifo #(
  parameter type T = cdc_fifo_pkg::packet_t
) (
  input  logic                  push_clk,
  input  logic                  push_rst,
  input  logic                  push_valid,
  input  T                      push_data,
  output logic                  push_ready,
  input  logic                  pop_clk,
  input  logic                  pop_rst,
  input  logic                  pop_ready,
  output logic                  pop_valid,
  output T                      pop_data,
  output cdc_fifo_pkg::count_t  pop_items
);

  logic                 push_beat;
  logic                 pop_beat;
  logic                 full;
  logic                 empty;
  logic                 reset_active_push;
  logic                 reset_active_push_sync;
  logic                 reset_active_pop;
  logic                 reset_active_pop_sync;
  cdc_fifo_pkg::count_t push_count_gray;
  cdc_fifo_pkg::count_t push_count_gray_sync;
  cdc_fifo_pkg::count_t pop_count_gray;
  cdc_fifo_pkg::count_t pop_count_gray_sync;
  cdc_fifo_pkg::addr_t  wr_addr;
  cdc_fifo_pkg::addr_t  rd_addr;

  assign push_ready = !full;
  assign pop_valid  = !empty;
  assign push_beat  = push_valid && push_ready;
  assign pop_beat   = pop_valid && pop_ready;

  cdc_fifo_push_flag_mgr push_flag_mgr_i (
    .clk               (push_clk),
    .rst               (push_rst),
    .push_beat         (push_beat),
    .pop_count_gray    (pop_count_gray_sync),
    .reset_active_pop  (reset_active_pop_sync),
    .push_count_gray   (push_count_gray),
    .wr_addr           (wr_addr),
    .full              (full),
    .reset_active_push (reset_active_push)
  );

  cdc_fifo_pop_flag_mgr pop_flag_mgr_i (
    .clk               (pop_clk),
    .rst               (pop_rst),
    .pop_beat          (pop_beat),
    .push_count_gray   (push_count_gray_sync),
    .reset_active_push (reset_active_push_sync),
    .pop_count_gray    (pop_count_gray),
    .rd_addr           (rd_addr),
    .items             (pop_items),
    .empty             (empty),
    .reset_active_pop  (reset_active_pop)
  );

  // Push to pop crossings
  cdc_fifo_sync #(.T(cdc_fifo_pkg::count_t)) push_count_sync_i (
    .clk (pop_clk),
    .rst (pop_rst),
    .in  (push_count_gray),
    .out (push_count_gray_sync)
  );

  cdc_fifo_sync #(.T(logic)) reset_active_push_sync_i (
    .clk (pop_clk),
    .rst (pop_rst),
    .in  (reset_active_push),
    .out (reset_active_push_sync)
  );

  // Pop to push crossings
  cdc_fifo_sync #(.T(cdc_fifo_pkg::count_t)) pop_count_sync_i (
    .clk (push_clk),
    .rst (push_rst),
    .in  (pop_count_gray),
    .out (pop_count_gray_sync)
  );

  cdc_fifo_sync #(.T(logic)) reset_active_pop_sync_i (
    .clk (push_clk),
    .rst (push_rst),
    .in  (reset_active_pop),
    .out (reset_active_pop_sync)
  );

  cdc_fifo_storage #(.T(T)) storage_i (
    .push_clk (push_clk),
    .wr_en    (push_beat),
    .wr_addr  (wr_addr),
    .wr_data  (push_data),
    .rd_addr  (rd_addr),
    .rd_data  (pop_data)
  );

endmodule

/* verification/cdc_fifo_tb.sv */
`timescale 1ns/1ps
`include "cdc_fifo_defines.svh"

module cdc_fifo_tb;

  localparam int stream_len    = 300;
  localparam int partial_fill  = 5;
  localparam int total_beats   = 2 * stream_len + `CDC_FIFO_DEPTH + partial_fill;
  localparam int timeout_limit = 2 * total_beats * 8 + 200;

  logic                  push_clk;
  logic                  push_rst;
  logic                  push_valid;
  cdc_fifo_pkg::packet_t push_data;
  logic                  push_ready;
  logic                  pop_clk;
  logic                  pop_rst;
  logic                  pop_ready;
  logic                  pop_valid;
  cdc_fifo_pkg::packet_t pop_data;
  cdc_fifo_pkg::count_t  pop_items;

  cdc_fifo_pkg::packet_t model [$];
  int error_count;
  int test_errors_at_start;
  int tests_run;
  int tests_failed;
  int cycle_count;

  cdc_fifo #(.T(cdc_fifo_pkg::packet_t)) cdc_fifo_i (
    .push_clk   (push_clk),
    .push_rst   (push_rst),
    .push_valid (push_valid),
    .push_data  (push_data),
    .push_ready (push_ready),
    .pop_clk    (pop_clk),
    .pop_rst    (pop_rst),
    .pop_ready  (pop_ready),
    .pop_valid  (pop_valid),
    .pop_data   (pop_data),
    .pop_items  (pop_items)
  );

  initial begin
    push_clk = 1'b0;
    forever #2 push_clk = ~push_clk;
  end

  // 6 ns against 4 ns keeps the two domains drifting apart
  initial begin
    pop_clk = 1'b0;
    forever #3 pop_clk = ~pop_clk;
  end

  function automatic cdc_fifo_pkg::packet_t random_packet();
    cdc_fifo_pkg::packet_t p;
    p.tag  = 4'($urandom);
    p.last = 1'($urandom);
    p.data = 16'($urandom);
    return p;
  endfunction

  task automatic check_packet(input string name, input cdc_fifo_pkg::packet_t actual,
                              input cdc_fifo_pkg::packet_t expected);
    if (actual !== expected) begin
      $display("MISMATCH %s: got 0x%06h expected 0x%06h", name, actual, expected);
      error_count++;
    end
  endtask

  task automatic check_count(input string name, input cdc_fifo_pkg::count_t actual,
                             input cdc_fifo_pkg::count_t expected);
    if (actual !== expected) begin
      $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, actual, expected);
      error_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, actual, expected);
      error_count++;
    end
  endtask

  task automatic start_test();
    test_errors_at_start = error_count;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (error_count == test_errors_at_start) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, error_count - test_errors_at_start);
    end
  endtask

  task automatic check_model_empty();
    if (model.size() != 0) begin
      $display("Model queue still holds %0d entries that never came out", model.size());
      error_count++;
    end
  endtask

  // Data only changes when no beat is pending
  task automatic push_stream(input int n, input int valid_pct);
    int sent;
    sent = 0;
    while (sent < n) begin
      @(posedge push_clk);
      if (push_valid && push_ready) begin
        model.push_back(push_data);
        sent++;
      end
      if (!push_valid || push_ready) begin
        if (sent < n && $urandom_range(99) < valid_pct) begin
          push_valid <= 1'b1;
          push_data  <= random_packet();
        end else begin
          push_valid <= 1'b0;
        end
      end
    end
  endtask

  task automatic pop_stream(input int n, input int ready_pct);
    int got;
    got = 0;
    while (got < n) begin
      @(posedge pop_clk);
      if (pop_valid && pop_ready) begin
        if (model.size() == 0) begin
          $display("Pop beat seen while the model queue was empty");
          error_count++;
        end else begin
          check_packet("pop_data", pop_data, model.pop_front());
        end
        got++;
      end
      pop_ready <= (got < n) && ($urandom_range(99) < ready_pct);
    end
  endtask

  // Pop side is stalled, push until ready falls and then keep offering for 50 cycles
  task automatic fill_until_full(output int accepted);
    accepted = 0;
    @(posedge push_clk);
    push_valid <= 1'b1;
    push_data  <= random_packet();
    do begin
      @(posedge push_clk);
      if (push_valid && push_ready) begin
        model.push_back(push_data);
        accepted++;
        push_data <= random_packet();
      end
    end while (push_ready && accepted <= `CDC_FIFO_DEPTH);
    // Valid stays high, so any rise of ready would take another beat
    repeat (50) begin
      @(posedge push_clk);
      check_flag("push_ready", push_ready, 1'b0);
      if (push_valid && push_ready) begin
        model.push_back(push_data);
        accepted++;
        push_data <= random_packet();
      end
    end
    push_valid <= 1'b0;
  endtask

  task automatic apply_reset();
    fork
      begin
        @(posedge push_clk);
        push_rst <= 1'b1;
        repeat (16) @(posedge push_clk);
        push_rst <= 1'b0;
      end
      begin
        @(posedge pop_clk);
        pop_rst <= 1'b1;
        repeat (16) @(posedge pop_clk);
        pop_rst <= 1'b0;
      end
    join
  endtask

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < timeout_limit) begin
      @(posedge push_clk);
      cycle_count++;
    end
    $display("Run timed out after %0d push clock cycles without finishing", cycle_count);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin : main
    int accepted;
    push_rst     = 1'b1;
    pop_rst      = 1'b1;
    push_valid   = 1'b0;
    push_data    = '0;
    pop_ready    = 1'b0;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    void'($urandom(32'h3a328f35));
    apply_reset();

    start_test();
    fork
      push_stream(stream_len, 70);
      pop_stream(stream_len, 60);
    join
    check_model_empty();
    finish_test("order_and_integrity");

    start_test();
    fill_until_full(accepted);
    if (accepted > 15) begin
      $display("Push side accepted %0d beats with the pop side stalled", accepted);
      error_count++;
    end else begin
      check_count("accepted_beats", cdc_fifo_pkg::count_t'(accepted), `CDC_FIFO_DEPTH);
    end
    finish_test("full_under_backpressure");

    start_test();
    repeat (20) @(posedge pop_clk);
    check_count("pop_items", pop_items, `CDC_FIFO_DEPTH);
    pop_stream(3, 100);
    repeat (20) @(posedge push_clk);
    @(posedge pop_clk);
    check_count("pop_items", pop_items, `CDC_FIFO_DEPTH - 3);
    finish_test("item_count");

    start_test();
    pop_stream(model.size(), 80);
    repeat (2) @(posedge pop_clk);
    check_flag("pop_valid", pop_valid, 1'b0);
    check_count("pop_items", pop_items, '0);
    check_model_empty();
    finish_test("drain");

    start_test();
    push_stream(partial_fill, 100);
    apply_reset();
    model.delete();
    repeat (8) @(posedge pop_clk);
    check_flag("pop_valid", pop_valid, 1'b0);
    check_count("pop_items", pop_items, '0);
    @(posedge push_clk);
    check_flag("push_ready", push_ready, 1'b1);
    fork
      push_stream(stream_len, 70);
      pop_stream(stream_len, 60);
    join
    check_model_empty();
    finish_test("reset_and_restart");

    $display("Tests run: %0d, tests failed: %0d, errors: %0d",
             tests_run, tests_failed, error_count);
    if (error_count == 0 && tests_failed == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+logic
logic/cdc_fifo_pkg.sv
logic/cdc_fifo_sync.sv
logic/cdc_fifo_push_flag_mgr.sv
logic/cdc_fifo_pop_flag_mgr.sv
logic/cdc_fifo_storage.sv
logic/cdc_fifo.sv
verification/cdc_fifo_tb.sv

/* Bender.yml */
package:
  name: cdc_fifo

sources:
  - target: any(rtl, test)
    include_dirs:
      - logic
    files:
      - logic/cdc_fifo_pkg.sv
      - logic/cdc_fifo_sync.sv
      - logic/cdc_fifo_push_flag_mgr.sv
      - logic/cdc_fifo_pop_flag_mgr.sv
      - logic/cdc_fifo_storage.sv
      - logic/cdc_fifo.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/cdc_fifo_tb.sv
